// File: mesm6_core.f
+incdir+include
design/mesm6_pkg.sv
design/mesm6_fetch.sv
design/mesm6_control.sv
design/mesm6_modifiers.sv
design/mesm6_accumulator.sv
design/mesm6_core.sv
verification/mesm6_core_assertions.sv
verification/mesm6_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the MESM-6 core testbench with Verilator
rm -f build.log sim.log
verilator --binary --assert --timing -f mesm6_core.f --top-module mesm6_core_tb \
    -o mesm6_sim > build.log 2>&1 && ./obj_dir/mesm6_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "simulation passed" || {
    echo "simulation failed, see build.log and sim.log"
    exit 1
}

// File: verification/mesm6_core_tb.sv
`timescale 1ns/1ps
`include "mesm6_defs.svh"

module mesm6_core_tb;

    logic                         clk;
    logic                         reset;
    logic                         ibus_fetch;
    logic [`MESM6_ADDR_BITS-1:0]  ibus_addr;
    logic [`MESM6_WORD_BITS-1:0]  ibus_input;
    logic                         ibus_done;
    logic                         dbus_read;
    logic                         dbus_write;
    logic [`MESM6_ADDR_BITS-1:0]  dbus_addr;
    logic [`MESM6_WORD_BITS-1:0]  dbus_output;
    logic [`MESM6_WORD_BITS-1:0]  dbus_input;
    logic                         dbus_done;
    logic                         halted;

    logic [`MESM6_WORD_BITS-1:0]  mem [1024];    // shared program and data memory
    logic [`MESM6_ADDR_BITS-1:0]  exp_addr [$];  // expected stores in order
    logic [`MESM6_WORD_BITS-1:0]  exp_data [$];
    logic [`MESM6_ADDR_BITS-1:0]  fetch_count;
    integer seed;
    integer iwait;
    integer dwait;
    integer cycles;
    integer store_errors;
    integer other_errors;

    mesm6_core mesm6_core_inst (.*);

    always #10 clk = ~clk;

    // --------------------------------------------------
    // instruction encoding
    // --------------------------------------------------
    function automatic logic [23:0] short_insn(input logic [3:0] idx, input logic [5:0] cmd,
                                               input logic [11:0] addr);
        return {idx, 1'b0, 1'b0, cmd, addr};  // bit 18 clear for a positive address
    endfunction

    function automatic logic [23:0] long_insn(input logic [3:0] idx, input logic [5:0] code,
                                              input logic [14:0] addr);
        return {idx, 1'b1, code[3:0], addr};  // code 020..037 keeps low 4 bits
    endfunction

    task automatic expect_store(input logic [14:0] addr, input logic [47:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_program();
        logic [47:0] d [6];
        logic [47:0] s;
        for (int i = 0; i < 1024; i++)
            mem[i[9:0]] = {i[15:0], i * 32'h9e37_79b9};  // fill from full address
        d[0] = 48'h1234_5678_9abc;
        d[1] = 48'hfedc_ba98_7654;  // sum wraps past 48 bits
        d[2] = 48'h0ff0_f0f0_ffff;
        d[3] = 48'h8000_0000_0001;
        d[4] = 48'h5555_aaaa_5555;
        d[5] = 48'h0;
        for (int i = 0; i < 6; i++)
            mem[10'h100 + i[9:0]] = d[i];
        mem[0]  = {short_insn(0, 6'o10, 12'h100), short_insn(0, 6'o00, 12'h200)};
        mem[1]  = {short_insn(0, 6'o04, 12'h101), short_insn(0, 6'o00, 12'h201)};
        mem[2]  = {short_insn(0, 6'o11, 12'h102), short_insn(0, 6'o00, 12'h202)};
        mem[3]  = {short_insn(0, 6'o15, 12'h103), short_insn(0, 6'o00, 12'h203)};
        mem[4]  = {short_insn(0, 6'o12, 12'h104), short_insn(0, 6'o00, 12'h204)};
        mem[5]  = {long_insn(0, 6'o25, 15'h010), short_insn(0, 6'o00, 12'h205)};  // utc
        mem[6]  = {short_insn(0, 6'o00, 12'h206), long_insn(3, 6'o24, 15'h020)};  // vtm M3
        mem[7]  = {short_insn(3, 6'o00, 12'h207), long_insn(0, 6'o24, 15'h030)};  // vtm M0
        mem[8]  = {short_insn(0, 6'o00, 12'h208), short_insn(0, 6'o10, 12'h105)};
        mem[9]  = {long_insn(0, 6'o34, 15'd11), short_insn(0, 6'o00, 12'h3ff)};   // uza
        mem[10] = {short_insn(0, 6'o00, 12'h3ff), short_insn(0, 6'o77, 12'h000)};
        mem[11] = {short_insn(0, 6'o10, 12'h100), long_insn(0, 6'o35, 15'd13)};   // u1a
        mem[12] = {short_insn(0, 6'o00, 12'h3ff), short_insn(0, 6'o00, 12'h3ff)};
        mem[13] = {long_insn(5, 6'o24, 15'h7ffd), short_insn(0, 6'o77, 12'h000)}; // M5 = -3
        mem[14] = {short_insn(0, 6'o77, 12'h000), long_insn(5, 6'o37, 15'd16)};   // vlm
        mem[15] = {short_insn(0, 6'o00, 12'h220), long_insn(0, 6'o33, 15'd0)};    // stop
        mem[16] = {short_insn(0, 6'o00, 12'h210), long_insn(0, 6'o30, 15'd14)};   // body, uj

        // expected stores from the instruction rules
        s = d[0];
        expect_store(15'h200, s);
        s = s + d[1];
        expect_store(15'h201, s);
        s = s & d[2];
        expect_store(15'h202, s);
        s = s | d[3];
        expect_store(15'h203, s);
        s = s ^ d[4];
        expect_store(15'h204, s);
        expect_store(15'h215, s);  // plus C
        expect_store(15'h206, s);  // C gone
        expect_store(15'h227, s);  // plus M3
        expect_store(15'h208, s);  // M0 still zero
        for (int i = 0; i < 3; i++)
            expect_store(15'h210, d[0]);
        expect_store(15'h220, d[0]);  // loop exit
    endtask

    task automatic check_store(input logic [14:0] addr, input logic [47:0] data);
        logic [14:0] ea;
        logic [47:0] ed;
        assert (addr != 15'h3ff) else begin
            $display("store reached the forbidden address, a branch was not taken");
            other_errors++;
        end
        if (exp_addr.size() == 0) begin
            $display("store beyond the expected list at address %h", addr);
            other_errors++;
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            assert (addr == ea) else begin
                $display("FAIL dbus_addr got %h expected %h", addr, ea);
                store_errors++;
            end
            assert (data == ed) else begin
                $display("FAIL dbus_output got %h expected %h", data, ed);
                store_errors++;
            end
        end
    endtask

    // --------------------------------------------------
    // memory model with random wait states
    // --------------------------------------------------
    always @(posedge clk) begin
        #1;
        if (reset) begin
            ibus_done = 1'b0;
            dbus_done = 1'b0;
        end else begin
            if (ibus_done) begin
                ibus_done = 1'b0;                 // taken at the last edge
            end else if (ibus_fetch) begin
                if (iwait == 0) begin
                    if (fetch_count < 15'd10) begin  // straight-line part
                        assert (ibus_addr == fetch_count) else begin
                            $display("FAIL ibus_addr got %h expected %h",
                                     ibus_addr, fetch_count);
                            other_errors++;
                        end
                    end
                    fetch_count++;
                    ibus_input = mem[ibus_addr[9:0]];
                    ibus_done  = 1'b1;
                    iwait      = $unsigned($random(seed)) % 4;
                end else begin
                    iwait--;
                end
            end
            if (dbus_done) begin
                dbus_done = 1'b0;
            end else if (dbus_read || dbus_write) begin
                if (dwait == 0) begin
                    if (dbus_write) begin
                        mem[dbus_addr[9:0]] = dbus_output;
                        check_store(dbus_addr, dbus_output);
                    end else begin
                        dbus_input = mem[dbus_addr[9:0]];
                    end
                    dbus_done = 1'b1;
                    dwait     = $unsigned($random(seed)) % 4;
                end else begin
                    dwait--;
                end
            end
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ibus_input   = '0;
        ibus_done    = 1'b0;
        dbus_input   = '0;
        dbus_done    = 1'b0;
        fetch_count  = '0;
        store_errors = 0;
        other_errors = 0;
        seed         = 32'h2e06_2b4b;
        iwait        = $unsigned($random(seed)) % 4;
        dwait        = $unsigned($random(seed)) % 4;
        load_program();
        repeat (3) @(posedge clk);
        #1;
        assert (!ibus_fetch && !dbus_read && !dbus_write && !halted) else begin
            $display("strobes or halted not low during reset");
            other_errors++;
        end
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < 3000) begin  // whole program with wait states
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("timeout: core hung, halted never rose");
            other_errors++;
        end else begin
            for (int i = 0; i < 20; i++) begin
                @(posedge clk);
                #1;
                assert (halted && !ibus_fetch && !dbus_read && !dbus_write) else begin
                    $display("core left halt or issued a request after stop");
                    other_errors++;
                end
            end
            assert (exp_addr.size() == 0) else begin
                $display("%0d expected stores never happened", exp_addr.size());
                other_errors++;
            end
        end
        $display("store errors %0d, other errors %0d", store_errors, other_errors);
        if (store_errors == 0 && other_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: verification/mesm6_core_assertions.sv
`timescale 1ns/1ps
`include "mesm6_defs.svh"

module mesm6_core_assertions (
    input logic                         clk,
    input logic                         reset,
    input logic                         ibus_fetch,
    input logic [`MESM6_ADDR_BITS-1:0]  ibus_addr,
    input logic                         ibus_done,
    input logic                         dbus_read,
    input logic                         dbus_write,
    input logic [`MESM6_ADDR_BITS-1:0]  dbus_addr,
    input logic [`MESM6_WORD_BITS-1:0]  dbus_output,
    input logic                         dbus_done,
    input logic                         halted
);

    // --------------------------------------------------
    // reset values and exclusive requests
    // --------------------------------------------------
    reset_idle: assert property (@(posedge clk)
        reset |=> !ibus_fetch && !dbus_read && !dbus_write && !halted)
        else $error("strobes or halted high after reset");

    read_write_excl: assert property (@(posedge clk) disable iff (reset)
        !(dbus_read && dbus_write))
        else $error("dbus read and write both high");

    no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(ibus_fetch && (dbus_read || dbus_write)))
        else $error("data request overlaps a fetch");

    // --------------------------------------------------
    // request held until done, dropped after
    // --------------------------------------------------
    fetch_hold: assert property (@(posedge clk) disable iff (reset)
        ibus_fetch && !ibus_done |=> ibus_fetch && $stable(ibus_addr))
        else $error("fetch request or address changed before done");

    read_hold: assert property (@(posedge clk) disable iff (reset)
        dbus_read && !dbus_done |=> dbus_read && $stable(dbus_addr))
        else $error("read request or address changed before done");

    write_hold: assert property (@(posedge clk) disable iff (reset)
        dbus_write && !dbus_done |=> dbus_write && $stable(dbus_addr)
            && $stable(dbus_output))
        else $error("write request, address or data changed before done");

    fetch_drop: assert property (@(posedge clk) disable iff (reset)
        ibus_fetch && ibus_done |=> !ibus_fetch)
        else $error("fetch request still high after done");

    data_drop: assert property (@(posedge clk) disable iff (reset)
        (dbus_read || dbus_write) && dbus_done |=> !dbus_read && !dbus_write)
        else $error("data request still high after done");

    // --------------------------------------------------
    // halt is final and quiet
    // --------------------------------------------------
    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped");

    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> !ibus_fetch && !dbus_read && !dbus_write)
        else $error("bus request while halted");

endmodule

bind mesm6_core mesm6_core_assertions assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .ibus_fetch  (ibus_fetch),
    .ibus_addr   (ibus_addr),
    .ibus_done   (ibus_done),
    .dbus_read   (dbus_read),
    .dbus_write  (dbus_write),
    .dbus_addr   (dbus_addr),
    .dbus_output (dbus_output),
    .dbus_done   (dbus_done),
    .halted      (halted)
);

// File: design/mesm6_core.sv
`timescale 1ns/1ps
`include "mesm6_defs.svh"

module mesm6_core (
    input  logic                         clk,
    input  logic                         reset,
    output logic                         ibus_fetch,   // instruction fetch request
    output logic [`MESM6_ADDR_BITS-1:0]  ibus_addr,
    input  logic [`MESM6_WORD_BITS-1:0]  ibus_input,
    input  logic                         ibus_done,
    output logic                         dbus_read,    // data read request
    output logic                         dbus_write,   // data write request
    output logic [`MESM6_ADDR_BITS-1:0]  dbus_addr,
    output logic [`MESM6_WORD_BITS-1:0]  dbus_output,
    input  logic [`MESM6_WORD_BITS-1:0]  dbus_input,
    input  logic                         dbus_done,
    output logic                         halted
);
    import mesm6_pkg::*;

    opcode_t                      opcode;
    logic [`MESM6_INDEX_BITS-1:0] index;
    logic [`MESM6_ADDR_BITS-1:0]  op_addr;
    logic [`MESM6_ADDR_BITS-1:0]  jump_addr;
    logic                         cache_hit, cache_load, decode_en;
    logic                         pc_step, pc_load, sel_full_addr;
    logic                         m_write, m_increment, c_write, acc_write;
    logic                         a_zero, m_zero;

    // --------------------------------------------------
    // units
    // --------------------------------------------------
    mesm6_fetch fetch_inst (
        .clk        (clk),
        .reset      (reset),
        .ibus_input (ibus_input),
        .cache_load (cache_load),
        .pc_step    (pc_step),
        .pc_load    (pc_load),
        .pc_target  (jump_addr),
        .ibus_addr  (ibus_addr),
        .cache_hit  (cache_hit),
        .opcode     (opcode),
        .index      (index),
        .op_addr    (op_addr)
    );

    mesm6_control control_inst (
        .clk           (clk),
        .reset         (reset),
        .cache_hit     (cache_hit),
        .opcode        (opcode),
        .a_zero        (a_zero),
        .m_zero        (m_zero),
        .ibus_done     (ibus_done),
        .dbus_done     (dbus_done),
        .ibus_fetch    (ibus_fetch),
        .dbus_read     (dbus_read),
        .dbus_write    (dbus_write),
        .cache_load    (cache_load),
        .decode_en     (decode_en),
        .pc_step       (pc_step),
        .pc_load       (pc_load),
        .sel_full_addr (sel_full_addr),
        .m_write       (m_write),
        .m_increment   (m_increment),
        .c_write       (c_write),
        .acc_write     (acc_write),
        .halted        (halted)
    );

    mesm6_modifiers modifiers_inst (
        .clk           (clk),
        .reset         (reset),
        .decode_en     (decode_en),
        .index         (index),
        .op_addr       (op_addr),
        .m_write       (m_write),
        .m_increment   (m_increment),
        .c_write       (c_write),
        .sel_full_addr (sel_full_addr),
        .exec_addr     (dbus_addr),     // data address is always exec address
        .jump_addr     (jump_addr),
        .m_zero        (m_zero)
    );

    mesm6_accumulator accumulator_inst (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .acc_write  (acc_write),
        .dbus_input (dbus_input),
        .acc        (dbus_output),      // only A goes to memory
        .a_zero     (a_zero)
    );

endmodule

// File: design/mesm6_accumulator.sv
`timescale 1ns/1ps
`include "mesm6_defs.svh"

module mesm6_accumulator (
    input  logic                         clk,
    input  logic                         reset,
    input  mesm6_pkg::opcode_t           opcode,
    input  logic                         acc_write,
    input  logic [`MESM6_WORD_BITS-1:0]  dbus_input,  // operand from memory
    output logic [`MESM6_WORD_BITS-1:0]  acc,         // A, also store data
    output logic                         a_zero
);
    import mesm6_pkg::*;

    // --------------------------------------------------
    // A register with logic and integer add
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (acc_write) begin
            case (opcode)
                op_xta:  acc <= dbus_input;
                op_add:  acc <= acc + dbus_input;   // plain 48-bit add, no float
                op_aax:  acc <= acc & dbus_input;
                op_aex:  acc <= acc ^ dbus_input;
                op_aox:  acc <= acc | dbus_input;
                default: acc <= acc;
            endcase
        end
    end

    // zero test for uza / u1a
    assign a_zero = (acc == '0);

endmodule

// File: design/mesm6_modifiers.sv
`timescale 1ns/1ps
`include "mesm6_defs.svh"

module mesm6_modifiers (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          decode_en,
    input  logic [`MESM6_INDEX_BITS-1:0]  index,
    input  logic [`MESM6_ADDR_BITS-1:0]   op_addr,
    input  logic                          m_write,        // vtm
    input  logic                          m_increment,    // vlm
    input  logic                          c_write,        // utc
    input  logic                          sel_full_addr,
    output logic [`MESM6_ADDR_BITS-1:0]   exec_addr,      // full + M[i]
    output logic [`MESM6_ADDR_BITS-1:0]   jump_addr,
    output logic                          m_zero
);

    logic [`MESM6_ADDR_BITS-1:0]  m [16];     // M0 never written
    logic [`MESM6_ADDR_BITS-1:0]  c;
    logic [`MESM6_ADDR_BITS-1:0]  full_addr;  // op_addr + C, latched
    logic [`MESM6_ADDR_BITS-1:0]  m_value;
    logic [`MESM6_INDEX_BITS-1:0] index_q;

    // --------------------------------------------------
    // address forming
    // --------------------------------------------------
    assign m_value   = m[index_q];
    assign exec_addr = full_addr + m_value;
    assign jump_addr = sel_full_addr ? full_addr : exec_addr;
    assign m_zero    = (m_value == '0);

    always_ff @(posedge clk) begin
        if (decode_en) begin
            full_addr <= op_addr + c;
            index_q   <= index;
        end
    end

    // --------------------------------------------------
    // modifier file and C
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                m[i] <= '0;
            c <= '0;
        end else begin
            if (index_q != '0) begin          // M0 reads as zero
                if (m_write)
                    m[index_q] <= full_addr;
                else if (m_increment)
                    m[index_q] <= m_value + 1'b1;
            end
            if (c_write)
                c <= exec_addr;
            else if (decode_en)
                c <= '0;                      // consumed by this decode
        end
    end

endmodule

// File: design/mesm6_control.sv
`timescale 1ns/1ps

module mesm6_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                cache_hit,
    input  mesm6_pkg::opcode_t  opcode,
    input  logic                a_zero,
    input  logic                m_zero,         // M[i] == 0
    input  logic                ibus_done,
    input  logic                dbus_done,
    output logic                ibus_fetch,
    output logic                dbus_read,
    output logic                dbus_write,
    output logic                cache_load,
    output logic                decode_en,
    output logic                pc_step,
    output logic                pc_load,
    output logic                sel_full_addr,  // jump to full address (vlm)
    output logic                m_write,
    output logic                m_increment,
    output logic                c_write,
    output logic                acc_write,
    output logic                halted
);
    import mesm6_pkg::*;

    state_t state;
    state_t state_next;

    // --------------------------------------------------
    // exec-cycle writes and jump decision
    // --------------------------------------------------
    always_comb begin
        pc_load       = 1'b0;
        sel_full_addr = 1'b0;
        m_write       = 1'b0;
        m_increment   = 1'b0;
        c_write       = 1'b0;
        if (state == st_exec) begin
            case (opcode)
                op_vtm: m_write = 1'b1;
                op_utc: c_write = 1'b1;       // C lives for one instruction
                op_uj:  pc_load = 1'b1;
                op_uza: pc_load = a_zero;
                op_u1a: pc_load = !a_zero;
                op_vlm: begin
                    sel_full_addr = 1'b1;
                    pc_load       = !m_zero;  // loop until M[i] reaches zero
                    m_increment   = !m_zero;
                end
                default: ;
            endcase
        end
    end

    assign pc_step = (state == st_exec) && !pc_load;  // fall through

    // --------------------------------------------------
    // state sequencing
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        cache_load = 1'b0;
        decode_en  = 1'b0;
        acc_write  = 1'b0;
        case (state)
            st_fetch: begin
                if (ibus_fetch && ibus_done) begin
                    cache_load = 1'b1;        // word captured at this edge
                    state_next = st_decode;
                end
            end
            st_decode: begin
                decode_en = 1'b1;
                case (opcode)
                    op_atx:                          state_next = st_write;
                    op_add, op_xta, op_aax, op_aex,
                    op_aox:                          state_next = st_read;
                    op_stop:                         state_next = st_halt;
                    default:                         state_next = st_exec;
                endcase
            end
            st_read: begin
                if (dbus_read && dbus_done) begin
                    acc_write  = 1'b1;        // operand taken with done
                    state_next = st_exec;
                end
            end
            st_write: begin
                if (dbus_write && dbus_done)
                    state_next = st_exec;
            end
            st_exec:  state_next = cache_hit ? st_decode : st_fetch;
            default:  state_next = st_halt;   // halt is final
        endcase
    end

    // strobes registered from the next state, so they drop after done
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_fetch;           // cache is empty after reset
            ibus_fetch <= 1'b0;
            dbus_read  <= 1'b0;
            dbus_write <= 1'b0;
        end else begin
            state      <= state_next;
            ibus_fetch <= (state_next == st_fetch);
            dbus_read  <= (state_next == st_read);
            dbus_write <= (state_next == st_write);
        end
    end

    assign halted = (state == st_halt);

endmodule

// File: design/mesm6_fetch.sv
`timescale 1ns/1ps
`include "mesm6_defs.svh"

module mesm6_fetch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`MESM6_WORD_BITS-1:0]   ibus_input,   // word from instruction bus
    input  logic                          cache_load,   // capture ibus_input
    input  logic                          pc_step,      // next half-word
    input  logic                          pc_load,      // jump
    input  logic [`MESM6_ADDR_BITS-1:0]   pc_target,    // jump word address
    output logic [`MESM6_ADDR_BITS-1:0]   ibus_addr,
    output logic                          cache_hit,    // word of next pc is cached
    output mesm6_pkg::opcode_t            opcode,
    output logic [`MESM6_INDEX_BITS-1:0]  index,
    output logic [`MESM6_ADDR_BITS-1:0]   op_addr       // address field, extended
);
    import mesm6_pkg::*;

    logic [`MESM6_PC_BITS-1:0]   pc;          // half-word granularity
    logic [`MESM6_PC_BITS-1:0]   pc_next;
    logic [`MESM6_WORD_BITS-1:0] cache_word;  // opcode cache
    logic [`MESM6_ADDR_BITS-1:0] cache_addr;  // word address of cache_word
    logic                        cache_valid;
    logic [`MESM6_INSN_BITS-1:0] insn;
    logic                        long_fmt;
    logic [3:0]                  long_cmd;    // 020..037 minus 020
    logic [5:0]                  short_cmd;   // 000..077

    // --------------------------------------------------
    // pc and cache
    // --------------------------------------------------
    always_comb begin
        pc_next = pc;
        if (pc_load)
            pc_next = {pc_target, 1'b0};      // jumps land on a left half
        else if (pc_step)
            pc_next = pc + 1'b1;
    end

    assign ibus_addr = pc[`MESM6_PC_BITS-1:1];
    // looks ahead at pc_next so exec can pick decode or fetch
    assign cache_hit = cache_valid && (pc_next[`MESM6_PC_BITS-1:1] == cache_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            cache_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (cache_load)
                cache_valid <= 1'b1;
            else if (pc_next[`MESM6_PC_BITS-1:1] != cache_addr)
                cache_valid <= 1'b0;          // pc left the cached word
        end
    end

    always_ff @(posedge clk) begin
        if (cache_load) begin
            cache_word <= ibus_input;
            cache_addr <= pc[`MESM6_PC_BITS-1:1];
        end
    end

    // --------------------------------------------------
    // field decoding
    // --------------------------------------------------
    assign insn = pc[0] ? cache_word[`MESM6_INSN_BITS-1:0]                    // right
                        : cache_word[`MESM6_WORD_BITS-1:`MESM6_INSN_BITS];   // left

    assign index     = insn[23:20];
    assign long_fmt  = insn[19];
    assign long_cmd  = insn[18:15];
    assign short_cmd = insn[17:12];
    assign op_addr   = long_fmt ? insn[14:0]
                                : {{3{insn[18]}}, insn[11:0]};  // sign from bit 18

    always_comb begin
        opcode = op_nop;                      // unknown codes fall through
        if (long_fmt) begin
            case (long_cmd)
                4'o04:   opcode = op_vtm;
                4'o05:   opcode = op_utc;
                4'o10:   opcode = op_uj;
                4'o13:   opcode = op_stop;
                4'o14:   opcode = op_uza;
                4'o15:   opcode = op_u1a;
                4'o17:   opcode = op_vlm;
                default: opcode = op_nop;
            endcase
        end else begin
            case (short_cmd)
                6'o00:   opcode = op_atx;
                6'o04:   opcode = op_add;
                6'o10:   opcode = op_xta;
                6'o11:   opcode = op_aax;
                6'o12:   opcode = op_aex;
                6'o15:   opcode = op_aox;
                default: opcode = op_nop;
            endcase
        end
    end

endmodule

// File: design/mesm6_pkg.sv
package mesm6_pkg;

    // --------------------------------------------------
    // decoded instruction
    // --------------------------------------------------
    typedef enum logic [3:0] {
        op_atx,     // 000 store A
        op_add,     // 004 integer add
        op_xta,     // 010 load A
        op_aax,     // 011 and
        op_aex,     // 012 xor
        op_aox,     // 015 or
        op_vtm,     // 024 M[i] = full address
        op_utc,     // 025 C = executive address
        op_uj,      // 030 jump
        op_stop,    // 033 halt
        op_uza,     // 034 jump if A zero
        op_u1a,     // 035 jump if A nonzero
        op_vlm,     // 037 loop on M[i]
        op_nop      // everything else
    } opcode_t;

    // --------------------------------------------------
    // controller states
    // --------------------------------------------------
    typedef enum logic [2:0] {
        st_fetch,   // cache miss, wait for ibus
        st_decode,  // latch address and index
        st_read,    // operand read on dbus
        st_exec,    // register writes, pc update
        st_write,   // store A on dbus
        st_halt     // stopped for good
    } state_t;

endpackage

// File: include/mesm6_defs.svh
`ifndef MESM6_DEFS_SVH
`define MESM6_DEFS_SVH

// --------------------------------------------------
// architectural widths, fixed by the MESM-6 format
// --------------------------------------------------

// data word, two instructions per word
`define MESM6_WORD_BITS   48

// one instruction, left or right half
`define MESM6_INSN_BITS   24

// word address on both buses
`define MESM6_ADDR_BITS   15

// pc counts half-words, lsb picks the half
`define MESM6_PC_BITS     16

// modifier number, M0..M15
`define MESM6_INDEX_BITS  4

`endif
